/* compile.f */
+incdir+tb
design/soc_pkg.sv
design/axi_lite_apb_bridge.sv
design/apb_decoder.sv
design/gpio_apb.sv
design/perip_soc_top.sv
tb/tb_perip_soc.sv

/* design/apb_decoder.sv */
// APB slot decoder
// One-hot slot select from the device field, response mux back
`timescale 1ns/1ps
`default_nettype none

module apb_decoder (
    input  wire                  psel_i,
    input  wire soc_pkg::addr_t  paddr_i,
    output logic [soc_pkg::APB_DEV_COUNT-1:0] slot_psel_o,
    input  wire soc_pkg::data_t  slot_prdata_i [soc_pkg::APB_DEV_COUNT],
    input  wire [soc_pkg::APB_DEV_COUNT-1:0]  slot_pready_i,
    input  wire [soc_pkg::APB_DEV_COUNT-1:0]  slot_pslverr_i,
    output soc_pkg::data_t       prdata_o,
    output logic                 pready_o,
    output logic                 pslverr_o
);

    import soc_pkg::*;

    logic [DEV_SEL_MSB-DEV_SEL_LSB:0] dev;

    assign dev = paddr_i[DEV_SEL_MSB:DEV_SEL_LSB];

    always_comb begin
        slot_psel_o = '0;
        if (psel_i) begin
            slot_psel_o = APB_DEV_COUNT'(1) << dev;
        end
    end

    // Response from whichever slot the address points at
    always_comb begin
        prdata_o  = slot_prdata_i[dev];
        pready_o  = slot_pready_i[dev];
        pslverr_o = slot_pslverr_i[dev];
    end

    // Never more than one slave selected
    always_comb begin
        a_sel_onehot : assert ($onehot0(slot_psel_o))
            else $error("apb_decoder: several slots selected %b", slot_psel_o);
    end

endmodule

`default_nettype wire

/* design/axi_lite_apb_bridge.sv */
// AXI-Lite slave to APB master bridge
// One outstanding transaction, four-state FSM
`timescale 1ns/1ps
`default_nettype none

module axi_lite_apb_bridge (
    input  wire                  clk,
    input  wire                  rst_n_i,
    // AXI-Lite write
    input  wire                  awvalid_i,
    input  wire soc_pkg::addr_t  awaddr_i,
    output logic                 awready_o,
    input  wire                  wvalid_i,
    input  wire soc_pkg::data_t  wdata_i,
    input  wire soc_pkg::strb_t  wstrb_i,
    output logic                 wready_o,
    output logic                 bvalid_o,
    output soc_pkg::resp_t       bresp_o,
    input  wire                  bready_i,
    // AXI-Lite read
    input  wire                  arvalid_i,
    input  wire soc_pkg::addr_t  araddr_i,
    output logic                 arready_o,
    output logic                 rvalid_o,
    output soc_pkg::data_t       rdata_o,
    output soc_pkg::resp_t       rresp_o,
    input  wire                  rready_i,
    // APB master
    output logic                 psel_o,
    output logic                 penable_o,
    output soc_pkg::addr_t       paddr_o,
    output logic                 pwrite_o,
    output soc_pkg::data_t       pwdata_o,
    output soc_pkg::strb_t       pstrb_o,
    input  wire soc_pkg::data_t  prdata_i,
    input  wire                  pready_i,
    input  wire                  pslverr_i
);

    import soc_pkg::*;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_SETUP,
        ST_ACCESS,
        ST_RESP
    } state_t;

    state_t state_q;
    logic   is_write_q;
    logic   wr_req;
    logic   resp_taken;
    addr_t  paddr_q;
    data_t  pwdata_q;
    strb_t  pstrb_q;
    data_t  rdata_q;
    resp_t  resp_q;

    // Write needs both channels; it wins over a read in the same cycle
    assign wr_req    = awvalid_i && wvalid_i;
    assign awready_o = (state_q == ST_IDLE) && wr_req;
    assign wready_o  = awready_o;
    assign arready_o = (state_q == ST_IDLE) && arvalid_i && !wr_req;

    assign resp_taken = is_write_q ? bready_i : rready_i;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q    <= ST_IDLE;
            is_write_q <= 1'b0;
        end else begin
            case (state_q)
                ST_IDLE: begin
                    if (awready_o || arready_o) begin
                        state_q    <= ST_SETUP;
                        is_write_q <= awready_o;
                    end
                end
                ST_SETUP:  state_q <= ST_ACCESS;
                ST_ACCESS: begin
                    if (pready_i) begin
                        state_q <= ST_RESP;
                    end
                end
                default: begin
                    if (resp_taken) begin
                        state_q <= ST_IDLE;
                    end
                end
            endcase
        end
    end

    // Request and response payload
    always_ff @(posedge clk) begin
        if (awready_o) begin
            paddr_q  <= awaddr_i;
            pwdata_q <= wdata_i;
            pstrb_q  <= wstrb_i;
        end else if (arready_o) begin
            paddr_q <= araddr_i;
            pstrb_q <= '0;  // APB reads carry no strobes
        end
        if (state_q == ST_ACCESS && pready_i) begin
            rdata_q <= is_write_q ? '0 : prdata_i;
            resp_q  <= pslverr_i ? RESP_SLVERR : RESP_OKAY;
        end
    end

    assign psel_o    = (state_q == ST_SETUP) || (state_q == ST_ACCESS);
    assign penable_o = (state_q == ST_ACCESS);
    assign paddr_o   = paddr_q;
    assign pwrite_o  = is_write_q;
    assign pwdata_o  = pwdata_q;
    assign pstrb_o   = pstrb_q;

    assign bvalid_o = (state_q == ST_RESP) && is_write_q;
    assign rvalid_o = (state_q == ST_RESP) && !is_write_q;
    assign bresp_o  = resp_q;
    assign rresp_o  = resp_q;
    assign rdata_o  = rdata_q;

    // Access phase only ever follows a setup phase
    a_penable_after_setup : assert property (@(posedge clk) disable iff (!rst_n_i)
        penable_o |-> psel_o && $past(psel_o));

    a_bresp_hold : assert property (@(posedge clk) disable iff (!rst_n_i)
        bvalid_o && !bready_i |=> bvalid_o && $stable(bresp_o));

    a_rresp_hold : assert property (@(posedge clk) disable iff (!rst_n_i)
        rvalid_o && !rready_i |=> rvalid_o && $stable(rdata_o) && $stable(rresp_o));

endmodule

`default_nettype wire

/* design/gpio_apb.sv */
// GPIO register block on APB
// Output, direction, input, irq enable and irq status registers
// Two-flop input synchronizer, rising edge interrupts
`timescale 1ns/1ps
`default_nettype none

module gpio_apb (
    input  wire                  clk,
    input  wire                  rst_n_i,
    input  wire                  psel_i,
    input  wire                  penable_i,
    input  wire                  pwrite_i,
    input  wire soc_pkg::addr_t  paddr_i,
    input  wire soc_pkg::data_t  pwdata_i,
    input  wire soc_pkg::strb_t  pstrb_i,
    output soc_pkg::data_t       prdata_o,
    output logic                 pready_o,
    output logic                 pslverr_o,
    input  wire soc_pkg::gpio_t  gpio_in_i,
    output soc_pkg::gpio_t       gpio_out_o,
    output soc_pkg::gpio_t       gpio_dir_o,
    output logic                 irq_o
);

    import soc_pkg::*;

    logic [REG_OFS_WIDTH-1:0] ofs;
    logic  wr_en;
    data_t wr_mask;
    gpio_t data_out_q;
    gpio_t dir_q;
    gpio_t irq_en_q;
    gpio_t irq_status_q;
    gpio_t sync1_q;
    gpio_t data_in_q;     // Second sync stage
    gpio_t in_prev_q;
    gpio_t rise;
    gpio_t status_clr;

    // Byte lanes enabled by the strobes
    function automatic data_t strb_to_mask(input strb_t strb);
        data_t mask;
        for (int i = 0; i < STRB_WIDTH; i++) begin
            mask[i*8 +: 8] = {8{strb[i]}};
        end
        return mask;
    endfunction

    assign ofs     = paddr_i[REG_OFS_WIDTH-1:0];
    assign wr_en   = psel_i && penable_i && pwrite_i;  // Always ready
    assign wr_mask = strb_to_mask(pstrb_i);

    assign rise       = data_in_q & ~in_prev_q;
    assign status_clr = (wr_en && ofs == REG_IRQ_STATUS) ? (pwdata_i & wr_mask) : '0;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            sync1_q   <= '0;
            data_in_q <= '0;
            in_prev_q <= '0;
        end else begin
            sync1_q   <= gpio_in_i;
            data_in_q <= sync1_q;
            in_prev_q <= data_in_q;
        end
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            data_out_q   <= '0;
            dir_q        <= '0;
            irq_en_q     <= '0;
            irq_status_q <= '0;
        end else begin
            if (wr_en) begin
                case (ofs)
                    REG_DATA_OUT: data_out_q <= (data_out_q & ~wr_mask) | (pwdata_i & wr_mask);
                    REG_DIR:      dir_q      <= (dir_q & ~wr_mask) | (pwdata_i & wr_mask);
                    REG_IRQ_EN:   irq_en_q   <= (irq_en_q & ~wr_mask) | (pwdata_i & wr_mask);
                    default: ;  // Data in and unknown offsets ignore writes
                endcase
            end
            // New edge wins over a clear in the same cycle
            irq_status_q <= (irq_status_q & ~status_clr) | rise;
        end
    end

    always_comb begin
        case (ofs)
            REG_DATA_OUT:   prdata_o = data_out_q;
            REG_DIR:        prdata_o = dir_q;
            REG_DATA_IN:    prdata_o = data_in_q;
            REG_IRQ_EN:     prdata_o = irq_en_q;
            REG_IRQ_STATUS: prdata_o = irq_status_q;
            default:        prdata_o = '0;
        endcase
    end

    assign pready_o   = 1'b1;
    assign pslverr_o  = 1'b0;
    assign gpio_out_o = data_out_q;
    assign gpio_dir_o = dir_q;
    assign irq_o      = |(irq_status_q & irq_en_q);

    a_wdata_known : assert property (@(posedge clk) disable iff (!rst_n_i)
        wr_en |-> !$isunknown(pwdata_i));

endmodule

`default_nettype wire

/* design/perip_soc_top.sv */
// Peripheral subsystem top
// AXI-Lite to APB bridge, slot decoder, two GPIO blocks, irq vector
`timescale 1ns/1ps
`default_nettype none

module perip_soc_top (
    input  wire                    clk,
    input  wire                    rst_n_i,
    input  wire                    awvalid_i,
    input  wire soc_pkg::addr_t    awaddr_i,
    output wire                    awready_o,
    input  wire                    wvalid_i,
    input  wire soc_pkg::data_t    wdata_i,
    input  wire soc_pkg::strb_t    wstrb_i,
    output wire                    wready_o,
    output wire                    bvalid_o,
    output wire soc_pkg::resp_t    bresp_o,
    input  wire                    bready_i,
    input  wire                    arvalid_i,
    input  wire soc_pkg::addr_t    araddr_i,
    output wire                    arready_o,
    output wire                    rvalid_o,
    output wire soc_pkg::data_t    rdata_o,
    output wire soc_pkg::resp_t    rresp_o,
    input  wire                    rready_i,
    input  wire soc_pkg::gpio_t    gpio0_in_i,
    output wire soc_pkg::gpio_t    gpio0_out_o,
    output wire soc_pkg::gpio_t    gpio0_dir_o,
    input  wire soc_pkg::gpio_t    gpio1_in_i,
    output wire soc_pkg::gpio_t    gpio1_out_o,
    output wire soc_pkg::gpio_t    gpio1_dir_o,
    output wire soc_pkg::irq_vec_t irq_o
);

    import soc_pkg::*;

    wire        psel;
    wire        penable;
    wire addr_t paddr;
    wire        pwrite;
    wire data_t pwdata;
    wire strb_t pstrb;
    wire data_t prdata;
    wire        pready;
    wire        pslverr;
    wire        gpio0_irq;
    wire        gpio1_irq;

    wire [APB_DEV_COUNT-1:0] slot_psel;
    wire data_t              slot_prdata [APB_DEV_COUNT];
    wire [APB_DEV_COUNT-1:0] slot_pready;
    wire [APB_DEV_COUNT-1:0] slot_pslverr;

    axi_lite_apb_bridge u_bridge (
        .clk       (clk),
        .rst_n_i   (rst_n_i),
        .awvalid_i (awvalid_i),
        .awaddr_i  (awaddr_i),
        .awready_o (awready_o),
        .wvalid_i  (wvalid_i),
        .wdata_i   (wdata_i),
        .wstrb_i   (wstrb_i),
        .wready_o  (wready_o),
        .bvalid_o  (bvalid_o),
        .bresp_o   (bresp_o),
        .bready_i  (bready_i),
        .arvalid_i (arvalid_i),
        .araddr_i  (araddr_i),
        .arready_o (arready_o),
        .rvalid_o  (rvalid_o),
        .rdata_o   (rdata_o),
        .rresp_o   (rresp_o),
        .rready_i  (rready_i),
        .psel_o    (psel),
        .penable_o (penable),
        .paddr_o   (paddr),
        .pwrite_o  (pwrite),
        .pwdata_o  (pwdata),
        .pstrb_o   (pstrb),
        .prdata_i  (prdata),
        .pready_i  (pready),
        .pslverr_i (pslverr)
    );

    apb_decoder u_decoder (
        .psel_i         (psel),
        .paddr_i        (paddr),
        .slot_psel_o    (slot_psel),
        .slot_prdata_i  (slot_prdata),
        .slot_pready_i  (slot_pready),
        .slot_pslverr_i (slot_pslverr),
        .prdata_o       (prdata),
        .pready_o       (pready),
        .pslverr_o      (pslverr)
    );

    gpio_apb u_gpio0 (
        .clk        (clk),
        .rst_n_i    (rst_n_i),
        .psel_i     (slot_psel[0]),
        .penable_i  (penable),
        .pwrite_i   (pwrite),
        .paddr_i    (paddr),
        .pwdata_i   (pwdata),
        .pstrb_i    (pstrb),
        .prdata_o   (slot_prdata[0]),
        .pready_o   (slot_pready[0]),
        .pslverr_o  (slot_pslverr[0]),
        .gpio_in_i  (gpio0_in_i),
        .gpio_out_o (gpio0_out_o),
        .gpio_dir_o (gpio0_dir_o),
        .irq_o      (gpio0_irq)
    );

    gpio_apb u_gpio1 (
        .clk        (clk),
        .rst_n_i    (rst_n_i),
        .psel_i     (slot_psel[1]),
        .penable_i  (penable),
        .pwrite_i   (pwrite),
        .paddr_i    (paddr),
        .pwdata_i   (pwdata),
        .pstrb_i    (pstrb),
        .prdata_o   (slot_prdata[1]),
        .pready_o   (slot_pready[1]),
        .pslverr_o  (slot_pslverr[1]),
        .gpio_in_i  (gpio1_in_i),
        .gpio_out_o (gpio1_out_o),
        .gpio_dir_o (gpio1_dir_o),
        .irq_o      (gpio1_irq)
    );

    // Slots above the GPIOs answer at once with an error
    for (genvar s = 2; s < APB_DEV_COUNT; s++) begin : g_unmapped
        assign slot_prdata[s]  = '0;
        assign slot_pready[s]  = 1'b1;
        assign slot_pslverr[s] = 1'b1;
    end

    assign irq_o = {gpio1_irq, gpio0_irq};

endmodule

`default_nettype wire

/* design/soc_pkg.sv */
// Shared widths and types for the peripheral subsystem
// APB address map, GPIO register offsets, AXI response codes
`default_nettype none

package soc_pkg;

    localparam int AXI_ADDR_WIDTH = 12;
    localparam int DATA_WIDTH     = 32;
    localparam int STRB_WIDTH     = DATA_WIDTH / 8;

    // Slots 0 and 1 are GPIO and the rest unmapped
    localparam int APB_DEV_COUNT = 4;
    localparam int DEV_SEL_MSB   = 9;
    localparam int DEV_SEL_LSB   = 8;
    localparam int REG_OFS_WIDTH = 8;

    localparam int GPIO_WIDTH = 32;
    localparam int IRQ_COUNT  = 2;

    // GPIO register offsets
    localparam logic [REG_OFS_WIDTH-1:0] REG_DATA_OUT   = 8'h00;
    localparam logic [REG_OFS_WIDTH-1:0] REG_DIR        = 8'h04;
    localparam logic [REG_OFS_WIDTH-1:0] REG_DATA_IN    = 8'h08;  // Read only
    localparam logic [REG_OFS_WIDTH-1:0] REG_IRQ_EN     = 8'h0C;
    localparam logic [REG_OFS_WIDTH-1:0] REG_IRQ_STATUS = 8'h10;  // W1C

    typedef logic [AXI_ADDR_WIDTH-1:0] addr_t;
    typedef logic [DATA_WIDTH-1:0]     data_t;
    typedef logic [STRB_WIDTH-1:0]     strb_t;
    typedef logic [1:0]                resp_t;
    typedef logic [GPIO_WIDTH-1:0]     gpio_t;
    typedef logic [IRQ_COUNT-1:0]      irq_vec_t;

    localparam resp_t RESP_OKAY   = 2'b00;
    localparam resp_t RESP_SLVERR = 2'b10;

endpackage

`default_nettype wire

/* run.sh */
#!/bin/sh
# Build and run the peripheral testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    -f compile.f \
    --top-module tb_perip_soc \
    -o sim_perip_soc

out=$(./obj_dir/sim_perip_soc)
printf '%s\n' "$out"

# Exit status follows the search for the pass line
printf '%s\n' "$out" | grep -qx "RESULT: PASS"

/* tb/tb_axi_tasks.svh */
// AXI-Lite master tasks for the peripheral testbench
// GPIO register model, expected read and irq values, typed compare tasks
`ifndef TB_AXI_TASKS_SVH
`define TB_AXI_TASKS_SVH

// Byte-strobed merge; w1c clears the bits written as one
function automatic data_t merge_write(input data_t old, input data_t wdata,
                                      input strb_t strb, input bit w1c);
    data_t res;
    res = old;
    for (int b = 0; b < STRB_WIDTH; b++) begin
        if (strb[b]) begin
            res[b*8 +: 8] = w1c ? (old[b*8 +: 8] & ~wdata[b*8 +: 8]) : wdata[b*8 +: 8];
        end
    end
    return res;
endfunction

function automatic data_t expected_read(input addr_t addr);
    logic idx;
    idx = addr[DEV_SEL_LSB];
    if (addr[DEV_SEL_MSB]) begin
        return '0;  // Slots 2 and 3
    end
    case (addr[REG_OFS_WIDTH-1:0])
        REG_DATA_OUT:   return m_out[idx];
        REG_DIR:        return m_dir[idx];
        REG_DATA_IN:    return m_in[idx];
        REG_IRQ_EN:     return m_en[idx];
        REG_IRQ_STATUS: return m_status[idx];
        default:        return '0;
    endcase
endfunction

function automatic irq_vec_t expected_irq();
    return {|(m_status[1] & m_en[1]), |(m_status[0] & m_en[0])};
endfunction

task automatic axi_write(input addr_t addr, input data_t data, input strb_t strb);
    int   stall;
    logic idx;
    stall = stall_en ? $urandom_range(0, 6) : 0;
    idx   = addr[DEV_SEL_LSB];
    exp_bresp.push_back(addr[DEV_SEL_MSB] ? RESP_SLVERR : RESP_OKAY);
    exp_bname.push_back(test_name);
    wr_issued++;
    if (!addr[DEV_SEL_MSB]) begin
        case (addr[REG_OFS_WIDTH-1:0])
            REG_DATA_OUT:   m_out[idx]    = merge_write(m_out[idx], data, strb, 1'b0);
            REG_DIR:        m_dir[idx]    = merge_write(m_dir[idx], data, strb, 1'b0);
            REG_IRQ_EN:     m_en[idx]     = merge_write(m_en[idx], data, strb, 1'b0);
            REG_IRQ_STATUS: m_status[idx] = merge_write(m_status[idx], data, strb, 1'b1);
            default: ;
        endcase
    end
    awvalid_i = 1'b1;
    awaddr_i  = addr;
    wvalid_i  = 1'b1;
    wdata_i   = data;
    wstrb_i   = strb;
    @(posedge clk);
    while (!awready_o) @(posedge clk);
    @(negedge clk);
    awvalid_i = 1'b0;
    wvalid_i  = 1'b0;
    repeat (stall) @(negedge clk);
    bready_i = 1'b1;
    @(posedge clk);
    while (!(bvalid_o && bready_i)) @(posedge clk);
    @(negedge clk);
    bready_i = 1'b0;
endtask

task automatic axi_read(input addr_t addr);
    int stall;
    stall = stall_en ? $urandom_range(0, 6) : 0;
    exp_rdata.push_back(expected_read(addr));
    exp_rresp.push_back(addr[DEV_SEL_MSB] ? RESP_SLVERR : RESP_OKAY);
    exp_rname.push_back(test_name);
    rd_issued++;
    arvalid_i = 1'b1;
    araddr_i  = addr;
    @(posedge clk);
    while (!arready_o) @(posedge clk);
    @(negedge clk);
    arvalid_i = 1'b0;
    repeat (stall) @(negedge clk);
    rready_i = 1'b1;
    @(posedge clk);
    while (!(rvalid_o && rready_i)) @(posedge clk);
    @(negedge clk);
    rready_i = 1'b0;
endtask

task automatic count_check(input bit ok, input string name, input string exp_s,
                           input string act_s);
    checks++;
    if (!ok) begin
        mismatches++;
        $display("mismatch %s: expected %s, actual %s", name, exp_s, act_s);
    end
endtask

task automatic check_data(input string name, input data_t exp, input data_t act);
    count_check(act === exp, name, $sformatf("%h", exp), $sformatf("%h", act));
endtask

task automatic check_resp(input string name, input resp_t exp, input resp_t act);
    count_check(act === exp, name, $sformatf("%b", exp), $sformatf("%b", act));
endtask

task automatic check_gpio(input string name, input gpio_t exp, input gpio_t act);
    count_check(act === exp, name, $sformatf("%h", exp), $sformatf("%h", act));
endtask

task automatic check_irq(input string name, input irq_vec_t exp, input irq_vec_t act);
    count_check(act === exp, name, $sformatf("%b", exp), $sformatf("%b", act));
endtask

`endif

/* tb/tb_perip_soc.sv */
// Testbench for the peripheral subsystem
// Clock, reset, watchdog, response checker and test sequence
`timescale 1ns/1ps
`default_nettype none

module tb_perip_soc;

    import soc_pkg::*;

    localparam int          TXN_COUNT    = 200;  // Upper bound for this sequence
    localparam int          RESET_CYCLES = 10;
    localparam time         CLK_PERIOD   = 10ns;
    localparam logic [31:0] SEED         = 32'h2a0a_31d7;
    // First three are read/write registers
    localparam logic [REG_OFS_WIDTH-1:0] REG_LIST [5] =
        '{REG_DATA_OUT, REG_DIR, REG_IRQ_EN, REG_DATA_IN, REG_IRQ_STATUS};

    logic     clk, rst_n_i;
    logic     awvalid_i, wvalid_i, bready_i, arvalid_i, rready_i;
    addr_t    awaddr_i, araddr_i;
    data_t    wdata_i;
    strb_t    wstrb_i;
    gpio_t    gpio0_in_i, gpio1_in_i;
    logic     awready_o, wready_o, bvalid_o, arready_o, rvalid_o;
    resp_t    bresp_o, rresp_o;
    data_t    rdata_o;
    gpio_t    gpio0_out_o, gpio0_dir_o, gpio1_out_o, gpio1_dir_o;
    irq_vec_t irq_o;

    gpio_t m_out [2];
    gpio_t m_dir [2];
    gpio_t m_en [2];
    gpio_t m_status [2];
    gpio_t m_in [2];

    resp_t exp_bresp [$];
    string exp_bname [$];
    data_t exp_rdata [$];
    resp_t exp_rresp [$];
    string exp_rname [$];

    int    checks, mismatches, other_errs;
    int    wr_issued, rd_issued, wr_seen, rd_seen;
    bit    stall_en = 1'b0;
    string test_name = "none";
    logic  b_wait = 1'b0;
    logic  r_wait = 1'b0;
    resp_t b_hold, r_hold;
    data_t rdata_hold;

    `include "tb_axi_tasks.svh"

    perip_soc_top dut (.*);

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #((TXN_COUNT * 50 + RESET_CYCLES) * CLK_PERIOD);
        $display("timeout: the test sequence did not finish in time");
        $display("RESULT: FAIL");
        $finish;
    end

    // Response checker on the rising edge
    always @(posedge clk) begin
        if (awready_o !== wready_o) begin
            other_errs++;
            $display("write address ready and write data ready differ");
        end
        if (b_wait && (!bvalid_o || bresp_o !== b_hold)) begin
            other_errs++;
            $display("write response changed before it was accepted");
        end
        if (r_wait && (!rvalid_o || rdata_o !== rdata_hold || rresp_o !== r_hold)) begin
            other_errs++;
            $display("read response changed before it was accepted");
        end
        if (bvalid_o && bready_i) begin
            wr_seen++;
            if (exp_bresp.size() == 0) begin
                other_errs++;
                $display("write response arrived with no write outstanding");
            end else begin
                check_resp(exp_bname.pop_front(), exp_bresp.pop_front(), bresp_o);
            end
        end
        if (rvalid_o && rready_i) begin
            rd_seen++;
            if (exp_rdata.size() == 0) begin
                other_errs++;
                $display("read response arrived with no read outstanding");
            end else begin
                check_resp(exp_rname[0], exp_rresp.pop_front(), rresp_o);
                check_data(exp_rname.pop_front(), exp_rdata.pop_front(), rdata_o);
            end
        end
        b_wait     = bvalid_o && !bready_i;
        r_wait     = rvalid_o && !rready_i;
        b_hold     = bresp_o;
        r_hold     = rresp_o;
        rdata_hold = rdata_o;
    end

    task automatic set_inputs(input gpio_t v0, input gpio_t v1);
        m_status[0] = m_status[0] | (v0 & ~m_in[0]);  // Rising edges only
        m_status[1] = m_status[1] | (v1 & ~m_in[1]);
        m_in[0]     = v0;
        m_in[1]     = v1;
        gpio0_in_i  = v0;
        gpio1_in_i  = v1;
        repeat (5) @(negedge clk);
    endtask

    task automatic read_all();
        for (int s = 0; s < 2; s++) begin
            for (int r = 0; r < 5; r++) begin
                axi_read({2'b00, 2'(s), REG_LIST[r]});
            end
        end
    endtask

    task automatic compare_pins();
        check_gpio({test_name, " gpio0_out"}, m_out[0], gpio0_out_o);
        check_gpio({test_name, " gpio0_dir"}, m_dir[0], gpio0_dir_o);
        check_gpio({test_name, " gpio1_out"}, m_out[1], gpio1_out_o);
        check_gpio({test_name, " gpio1_dir"}, m_dir[1], gpio1_dir_o);
        check_irq({test_name, " irq"}, expected_irq(), irq_o);
    endtask

    initial begin
        logic [1:0] slot;
        int         idx;
        addr_t      addr;
        gpio_t      pin;
        void'($urandom(SEED));
        {awvalid_i, wvalid_i, bready_i, arvalid_i, rready_i} = '0;
        awaddr_i = '0;
        araddr_i = '0;
        wdata_i  = '0;
        wstrb_i  = '0;
        rst_n_i  = 1'b0;
        for (int s = 0; s < 2; s++) begin
            {m_out[s], m_dir[s], m_en[s], m_status[s], m_in[s]} = '0;
        end
        gpio0_in_i = '0;
        gpio1_in_i = '0;
        repeat (RESET_CYCLES) @(negedge clk);
        rst_n_i = 1'b1;
        @(negedge clk);

        test_name = "reset_values";
        read_all();
        compare_pins();

        test_name = "rw_strobes";
        repeat (30) begin
            slot = 2'($urandom_range(0, 1));
            idx  = $urandom_range(0, 2);
            addr = {2'b00, slot, REG_LIST[idx]};
            axi_write(addr, data_t'($urandom), strb_t'($urandom));
            compare_pins();
            axi_read(addr);
        end

        test_name = "data_in";
        repeat (6) begin
            set_inputs(gpio_t'($urandom), gpio_t'($urandom));
            axi_read({4'b0000, REG_DATA_IN});
            axi_read({4'b0001, REG_DATA_IN});
            slot = 2'($urandom_range(0, 1));
            axi_write({2'b00, slot, REG_DATA_IN}, data_t'($urandom), '1);  // Read only
            axi_read({2'b00, slot, REG_DATA_IN});
            compare_pins();
        end

        test_name = "irq_edges";
        set_inputs('0, '0);
        for (int s = 0; s < 2; s++) begin
            axi_write({2'b00, 2'(s), REG_IRQ_STATUS}, '1, '1);
            axi_write({2'b00, 2'(s), REG_IRQ_EN}, '1, '1);
        end
        compare_pins();
        for (int s = 0; s < 2; s++) begin
            pin = gpio_t'(1) << $urandom_range(0, GPIO_WIDTH - 1);
            set_inputs(s == 0 ? pin : '0, s == 1 ? pin : '0);
            compare_pins();
            axi_read({2'b00, 2'(s), REG_IRQ_STATUS});
            axi_write({2'b00, 2'(s), REG_IRQ_STATUS}, pin, '1);
            compare_pins();
            set_inputs('0, '0);  // Falling edge on a cleared bit
            axi_read({2'b00, 2'(s), REG_IRQ_STATUS});
            compare_pins();
        end

        test_name = "unmapped_slots";
        for (int s = 2; s < APB_DEV_COUNT; s++) begin
            idx = $urandom_range(0, 4);
            axi_write({2'b00, 2'(s), REG_LIST[idx]}, data_t'($urandom), strb_t'($urandom));
            axi_read({2'b00, 2'(s), REG_LIST[idx]});
        end
        read_all();
        compare_pins();

        test_name = "ready_stalls";
        stall_en  = 1'b1;
        repeat (40) begin
            slot = 2'($urandom_range(0, 3));
            idx  = $urandom_range(0, 4);
            addr = {2'b00, slot, REG_LIST[idx]};
            if ($urandom_range(0, 1) == 1) begin
                axi_write(addr, data_t'($urandom), strb_t'($urandom));
            end else begin
                axi_read(addr);
            end
        end
        read_all();
        compare_pins();

        repeat (3) @(negedge clk);
        if (wr_seen != wr_issued || rd_seen != rd_issued) begin
            other_errs++;
            $display("response count differs: writes %0d of %0d, reads %0d of %0d",
                     wr_seen, wr_issued, rd_seen, rd_issued);
        end
        $display("checks %0d, mismatches %0d, other errors %0d", checks, mismatches, other_errs);
        if (mismatches == 0 && other_errs == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire
